// ==== divPkg.sv ====
package divPkg;

    ////////////////////////////////////////////////////////////
    // widths and pipeline shape
    ////////////////////////////////////////////////////////////

    // one operand word
    localparam int DataWidth = 16;

    // array rows evaluated between two pipeline registers
    localparam int RowsPerStage = 4;

    localparam int NumStages = DataWidth / RowsPerStage;

    // input stage + row stages + output stage
    localparam int Latency = NumStages + 2;

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    // operand, magnitude, quotient or remainder
    typedef logic [DataWidth-1:0] data_t;

    // two's complement minimum, the one value without a magnitude
    localparam data_t MostNegative = {1'b1, {(DataWidth-1){1'b0}}};

    // state carried from one pipeline stage to the next
    typedef struct packed {
        logic  valid;
        // operand signs differ
        logic  negate;
        logic  err;
        // dividend magnitude, bits consumed from the top down
        data_t dividendBits;
        data_t divisorMag;
        data_t partialRem;
        // filled in from the msb down
        data_t quotient;
    } divWork_t;

endpackage

// ==== operandCondition.sv ====
`timescale 1ns/1ps

module operandCondition import divPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     inValid,
    input  data_t    dividend,
    input  data_t    divisor,
    output divWork_t work
);

    data_t    dividendMag;
    data_t    divisorMag;
    logic     errNext;
    divWork_t workNext;

    ////////////////////////////////////////////////////////////
    // magnitudes and error detection
    ////////////////////////////////////////////////////////////

    assign dividendMag = dividend[DataWidth-1] ? (~dividend + 1'b1) : dividend;
    assign divisorMag  = divisor[DataWidth-1] ? (~divisor + 1'b1) : divisor;

    // the minimum value maps onto itself, so it shows up in the magnitude
    assign errNext = (dividendMag == MostNegative) ||
                     (divisorMag == MostNegative) ||
                     (divisorMag == '0);

    always_comb begin
        workNext              = '0;
        workNext.valid        = inValid;
        workNext.negate       = dividend[DataWidth-1] ^ divisor[DataWidth-1];
        workNext.err          = errNext;
        workNext.dividendBits = dividendMag;
        workNext.divisorMag   = divisorMag;
        // partialRem and quotient start cleared
    end

    ////////////////////////////////////////////////////////////
    // input register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            work.valid <= 1'b0;
        end else begin
            work <= workNext;
        end
    end

    // a zero divisor must never reach the array unflagged
    zeroDivisorFlagged: assert property (
        @(posedge clk) disable iff (!arstN)
        (inValid && (divisor == '0)) |=> (work.valid && work.err)
    );

endmodule

// ==== divRow.sv ====
`timescale 1ns/1ps

module divRow import divPkg::*; (
    input  data_t partialRemIn,
    input  logic  dividendBit,
    input  data_t divisorMag,
    output data_t partialRemOut,
    output logic  quotientBit
);

    // remainder after the shift, with the bit that fell off the top
    data_t              shiftedRem;
    logic               shiftedOut;
    // one extra bit so the msb is the borrow
    logic [DataWidth:0] trialDiff;
    logic               borrow;

    ////////////////////////////////////////////////////////////
    // shift in the next dividend bit
    ////////////////////////////////////////////////////////////

    assign {shiftedOut, shiftedRem} = {partialRemIn, dividendBit};

    ////////////////////////////////////////////////////////////
    // trial subtraction
    ////////////////////////////////////////////////////////////

    assign trialDiff = {1'b0, shiftedRem} - {1'b0, divisorMag};
    assign borrow    = trialDiff[DataWidth];

    // a lost top bit means the shifted value was larger than any divisor
    assign quotientBit = ~borrow | shiftedOut;

    // restore on borrow, otherwise keep the difference
    assign partialRemOut = quotientBit ? trialDiff[DataWidth-1:0] : shiftedRem;

endmodule

// ==== divStage.sv ====
`timescale 1ns/1ps

module divStage import divPkg::*; #(
    parameter int stageIndex = 0
) (
    input  logic     clk,
    input  logic     arstN,
    input  divWork_t workIn,
    output divWork_t workOut
);

    // highest dividend / quotient bit handled in this stage
    localparam int TopBit = DataWidth - 1 - stageIndex * RowsPerStage;

    data_t                   remChain [RowsPerStage+1];
    logic [RowsPerStage-1:0] stageQuot;
    divWork_t                workNext;

    ////////////////////////////////////////////////////////////
    // row chain
    ////////////////////////////////////////////////////////////

    assign remChain[0] = workIn.partialRem;

    for (genvar row = 0; row < RowsPerStage; row++) begin : gRow
        divRow rowInst (
            .partialRemIn  (remChain[row]),
            .dividendBit   (workIn.dividendBits[TopBit-row]),
            .divisorMag    (workIn.divisorMag),
            .partialRemOut (remChain[row+1]),
            .quotientBit   (stageQuot[RowsPerStage-1-row])
        );
    end

    always_comb begin
        workNext            = workIn;
        workNext.partialRem = remChain[RowsPerStage];
        // first row gives the most significant bit of this group
        workNext.quotient[TopBit -: RowsPerStage] = stageQuot;
    end

    ////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            workOut.valid <= 1'b0;
        end else begin
            workOut <= workNext;
        end
    end

    // restoring invariant across every row of the array so far
    remBelowDivisor: assert property (
        @(posedge clk) disable iff (!arstN)
        (workOut.valid && !workOut.err) |-> (workOut.partialRem < workOut.divisorMag)
    );

endmodule

// ==== resultFormat.sv ====
`timescale 1ns/1ps

module resultFormat import divPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  divWork_t work,
    output logic     outValid,
    output data_t    quotient,
    output data_t    remainder,
    output logic     err
);

    data_t signedQuot;

    ////////////////////////////////////////////////////////////
    // sign correction
    ////////////////////////////////////////////////////////////

    assign signedQuot = work.negate ? (~work.quotient + 1'b1) : work.quotient;

    ////////////////////////////////////////////////////////////
    // output registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= work.valid;
        end
    end

    always_ff @(posedge clk) begin
        quotient <= signedQuot;
        // remainder stays a plain magnitude
        remainder <= work.partialRem;
        err       <= work.err;
    end

    // strobe must be clean once reset is gone
    outValidKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        !$isunknown(outValid)
    );

endmodule

// ==== divTop.sv ====
`timescale 1ns/1ps

module divTop import divPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  inValid,
    input  data_t dividend,
    input  data_t divisor,
    output logic  outValid,
    output data_t quotient,
    output data_t remainder,
    output logic  err
);

    // entry 0 leaves the input stage, entry NumStages the last row stage
    divWork_t stageWork [NumStages+1];

    ////////////////////////////////////////////////////////////
    // input stage
    ////////////////////////////////////////////////////////////

    operandCondition condInst (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .dividend (dividend),
        .divisor  (divisor),
        .work     (stageWork[0])
    );

    ////////////////////////////////////////////////////////////
    // row stages
    ////////////////////////////////////////////////////////////

    for (genvar stage = 0; stage < NumStages; stage++) begin : gStage
        divStage #(
            .stageIndex (stage)
        ) stageInst (
            .clk     (clk),
            .arstN   (arstN),
            .workIn  (stageWork[stage]),
            .workOut (stageWork[stage+1])
        );
    end

    ////////////////////////////////////////////////////////////
    // output stage
    ////////////////////////////////////////////////////////////

    resultFormat formatInst (
        .clk       (clk),
        .arstN     (arstN),
        .work      (stageWork[NumStages]),
        .outValid  (outValid),
        .quotient  (quotient),
        .remainder (remainder),
        .err       (err)
    );

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic arstN
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 16 cycles of reset, released on a falling edge
    initial begin
        arstN = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

// ==== divChecker.sv ====
`timescale 1ns/1ps

module divChecker import divPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  inValid,
    input  data_t dividend,
    input  data_t divisor,
    input  logic  outValid,
    input  data_t quotient,
    input  data_t remainder,
    input  logic  err,
    output int    valueErrors,
    output int    latencyErrors,
    output int    missingResults,
    output int    extraResults,
    output int    pendingCount
);

    typedef struct packed {
        data_t       dividend;
        data_t       divisor;
        logic        err;
        data_t       quotient;
        data_t       remainder;
        logic [31:0] inCycle;
    } expect_t;

    expect_t     expectQ [$];
    logic [31:0] cycle;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic expect_t refDivide(data_t a, data_t b);
        int      sa;
        int      sb;
        int      magA;
        int      magB;
        int      q;
        int      r;
        expect_t e;
        sa = $signed(a);
        sb = $signed(b);
        e = '0;
        e.dividend = a;
        e.divisor = b;
        e.err = (sa == -(1 << (DataWidth - 1))) || (sb == -(1 << (DataWidth - 1))) || (sb == 0);
        if (!e.err) begin
            magA = (sa < 0) ? -sa : sa;
            magB = (sb < 0) ? -sb : sb;
            q = magA / magB;
            r = magA % magB;
            // quotient takes the sign, remainder stays a magnitude
            if ((sa < 0) != (sb < 0)) q = -q;
            e.quotient = q[DataWidth-1:0];
            e.remainder = r[DataWidth-1:0];
        end
        return e;
    endfunction

    task automatic compareField(string name, data_t expVal, data_t gotVal, expect_t e);
        if (gotVal !== expVal) begin
            $display("CHECK FAILED %s: expected 0x%04h, got 0x%04h (dividend 0x%04h, divisor 0x%04h)",
                     name, expVal, gotVal, e.dividend, e.divisor);
            valueErrors++;
        end
    endtask

    initial begin
        valueErrors = 0;
        latencyErrors = 0;
        missingResults = 0;
        extraResults = 0;
        pendingCount = 0;
    end

    ////////////////////////////////////////////////////////////
    // compare process
    ////////////////////////////////////////////////////////////

    always @(posedge clk or negedge arstN) begin
        expect_t head;
        expect_t fresh;
        if (!arstN) begin
            cycle = 0;
            expectQ.delete();
        end else begin
            cycle = cycle + 1;
            if (outValid === 1'b1) begin
                if (expectQ.size() == 0) begin
                    $display("unexpected result at cycle %0d with no operation pending", cycle);
                    extraResults++;
                end else begin
                    head = expectQ.pop_front();
                    compareField("err", {{(DataWidth-1){1'b0}}, head.err},
                                 {{(DataWidth-1){1'b0}}, err}, head);
                    if (!head.err) begin
                        compareField("quotient", head.quotient, quotient, head);
                        compareField("remainder", head.remainder, remainder, head);
                    end
                    if (cycle - head.inCycle != Latency) begin
                        $display("result for dividend 0x%04h divisor 0x%04h came after %0d cycles, not %0d",
                                 head.dividend, head.divisor, cycle - head.inCycle, Latency);
                        latencyErrors++;
                    end
                end
            end else if (outValid !== 1'b0) begin
                $display("outValid is unknown at cycle %0d", cycle);
                valueErrors++;
            end
            // give up on a result well past its slot
            if (expectQ.size() > 0 && (cycle - expectQ[0].inCycle > Latency + 2)) begin
                $display("no result seen for dividend 0x%04h divisor 0x%04h within %0d cycles",
                         expectQ[0].dividend, expectQ[0].divisor, Latency + 2);
                missingResults++;
                void'(expectQ.pop_front());
            end
            if (inValid === 1'b1) begin
                fresh = refDivide(dividend, divisor);
                fresh.inCycle = cycle;
                expectQ.push_back(fresh);
            end
            pendingCount = expectQ.size();
        end
    end

endmodule

// ==== divTb.sv ====
`timescale 1ns/1ps

module divTb import divPkg::*; ;

    logic  clk;
    logic  arstN;
    logic  inValid;
    data_t dividend;
    data_t divisor;
    logic  outValid;
    data_t quotient;
    data_t remainder;
    logic  err;
    int    seed;
    int    timeouts;
    int    valueErrors;
    int    latencyErrors;
    int    missingResults;
    int    extraResults;
    int    pendingCount;

    tbClock clockInst (.clk(clk), .arstN(arstN));

    divTop dut_i (
        .clk(clk), .arstN(arstN), .inValid(inValid), .dividend(dividend), .divisor(divisor),
        .outValid(outValid), .quotient(quotient), .remainder(remainder), .err(err)
    );

    divChecker monitorInst (
        .clk(clk), .arstN(arstN), .inValid(inValid), .dividend(dividend), .divisor(divisor),
        .outValid(outValid), .quotient(quotient), .remainder(remainder), .err(err),
        .valueErrors(valueErrors), .latencyErrors(latencyErrors),
        .missingResults(missingResults), .extraResults(extraResults),
        .pendingCount(pendingCount)
    );

    ////////////////////////////////////////////////////////////
    // stimulus tasks, all on the falling edge
    ////////////////////////////////////////////////////////////

    task automatic sendOp(input int a, input int b);
        @(negedge clk);
        inValid = 1'b1;
        dividend = a[DataWidth-1:0];
        divisor = b[DataWidth-1:0];
    endtask

    // junk on the data lines while idle
    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            inValid = 1'b0;
            dividend = data_t'($random(seed));
            divisor = data_t'($random(seed));
        end
    endtask

    task automatic sendIsolated(input int a, input int b);
        sendOp(a, b);
        idleCycles(Latency + 2);
    endtask

    task automatic waitForReset();
        int count;
        count = 0;
        while (arstN !== 1'b1 && count < 100) begin
            @(posedge clk);
            count++;
        end
        if (arstN !== 1'b1) begin
            $display("reset was never released");
            timeouts++;
        end
    endtask

    task automatic waitForDrain();
        int count;
        count = 0;
        while (pendingCount != 0 && count < 50) begin
            @(negedge clk);
            count++;
        end
        if (pendingCount != 0) begin
            $display("%0d results still pending after the drain timeout", pendingCount);
            timeouts++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int a;
        int b;
        seed = 21;
        timeouts = 0;
        inValid = 1'b0;
        dividend = '0;
        divisor = '0;
        waitForReset();
        if (timeouts == 0) begin
            // quiet period, outValid must stay low
            idleCycles(10);
            sendIsolated(100, 7);
            sendIsolated(32767, 1);
            sendIsolated(5, 9);
            sendIsolated(1000, 1000);
            sendIsolated(32767, 32767);
            sendIsolated(12345, 123);
            // sign combinations
            sendIsolated(-100, 7);
            sendIsolated(100, -7);
            sendIsolated(-100, -7);
            sendIsolated(-32767, 2);
            // error cases and their neighbors
            sendIsolated(123, 0);
            sendIsolated(-32768, 3);
            sendIsolated(77, -32768);
            sendIsolated(-32768, 0);
            sendIsolated(123, 1);
            sendIsolated(-32767, 3);
            sendIsolated(77, -32767);
            sendIsolated(-32767, -1);
            // back-to-back stream, half with small divisors
            for (int i = 0; i < 200; i++) begin
                a = $random(seed);
                b = $random(seed);
                if (b[0]) b = b % 97;
                sendOp(a, b);
            end
            // stream with random gaps
            for (int i = 0; i < 200; i++) begin
                if (($random(seed) & 3) == 0) begin
                    idleCycles(1);
                end else begin
                    a = $random(seed);
                    b = $random(seed) % 301;
                    sendOp(a, b);
                end
            end
            idleCycles(Latency + 4);
            waitForDrain();
        end
        $display("errors: value %0d, latency %0d, missing %0d, extra %0d, timeouts %0d",
                 valueErrors, latencyErrors, missingResults, extraResults, timeouts);
        if (valueErrors + latencyErrors + missingResults + extraResults + timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
divPkg.sv
operandCondition.sv
divRow.sv
divStage.sv
resultFormat.sv
divTop.sv
tbClock.sv
divChecker.sv
divTb.sv

// ==== Makefile ====
# Verilator flow for the pipelined signed divider

TOP = divTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -o divSim
	./obj_dir/divSim | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
